/* hdl/emesh_axi_defs.svh */
`ifndef EMESH_AXI_DEFS_SVH
`define EMESH_AXI_DEFS_SVH

//############################################################
// emesh side
//############################################################
`define EMESH_AW 32  // emesh address width
`define EMESH_DW 32  // emesh data width

//############################################################
// axi side
//############################################################
`define AXI_DW   64  // axi data bus width
`define AXI_STW  8   // one strobe per data byte
`define AXI_IDW  6   // id width, ids are tied to 0

// queue depths, entries
`define WR_DEPTH 4   // write packet queue
`define RD_DEPTH 4   // read request queue and outstanding tags

`endif

/* hdl/emesh_pkg.sv */
`include "emesh_axi_defs.svh"

package emesh_pkg;

   // transfer size of one emesh access
   typedef enum logic [1:0] {
      DM_BYTE   = 2'd0,  // 8 bit
      DM_HALF   = 2'd1,  // 16 bit
      DM_WORD   = 2'd2,  // 32 bit
      DM_DOUBLE = 2'd3   // 64 bit, upper word rides in srcaddr
   } datamode_e;

   // full emesh packet, 103 bits
   typedef struct packed {
      logic                 write;     // 1 write, 0 read
      datamode_e            datamode;
      logic [3:0]           ctrlmode;  // passed through untouched
      logic [`EMESH_AW-1:0] dstaddr;   // target address
      logic [`EMESH_AW-1:0] srcaddr;   // return address, or upper data word
      logic [`EMESH_DW-1:0] data;      // lower data word
   } emesh_packet_t;

endpackage

/* hdl/axi_pkg.sv */
`include "emesh_axi_defs.svh"

package axi_pkg;

   typedef logic [31:0]          axi_addr_t;  // byte address
   typedef logic [`AXI_DW-1:0]   axi_data_t;  // one data beat
   typedef logic [`AXI_STW-1:0]  axi_strb_t;  // byte lane enables
   typedef logic [2:0]           axi_size_t;  // log2 of bytes per beat

   // response codes
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axi_resp_e;

   // what a read needs to build its reply once R data is back.
   // offset keeps dstaddr[2:0]; bit 2 is the lane select, bits 1:0 the byte
   // offset inside the lane
   typedef struct packed {
      logic [2:0]           offset;    // lane select and byte offset
      emesh_pkg::datamode_e datamode;  // size of the reply
      logic [3:0]           ctrlmode;  // echoed back
      logic [`EMESH_AW-1:0] retaddr;   // requester srcaddr
   } rd_tag_t;

endpackage

/* hdl/packet_fifo.sv */
`timescale 1ns/1ns

module packet_fifo #(
   parameter int  DEPTH   = 4,
   parameter type entry_t = logic
) (
   input  logic   aclk,
   input  logic   rst,
   input  logic   push,       // ignored while full
   input  entry_t push_data,
   input  logic   pop,        // ignored while empty
   output entry_t pop_data,   // show-ahead head entry
   output logic   empty,
   output logic   full
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   entry_t        mem [DEPTH];  // circular storage
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;        // entries held
   logic          do_push;
   logic          do_pop;

   function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
      return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;  // wrap for any depth
   endfunction

   assign do_push  = push & ~full;
   assign do_pop   = pop & ~empty;
   assign empty    = (count == '0);
   assign full     = (count == CW'(DEPTH));
   assign pop_data = mem[rd_ptr];

   always_ff @(posedge aclk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= next_ptr(wr_ptr);
         if (do_pop) rd_ptr <= next_ptr(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   always_ff @(posedge aclk) begin
      if (do_push) mem[wr_ptr] <= push_data;  // payload only
   end

endmodule

/* hdl/axi_master_wr.sv */
`timescale 1ns/1ns
`include "emesh_axi_defs.svh"

module axi_master_wr (
   input  logic                 aclk,
   input  logic                 rst,
   input  logic                 emesh_access_outb,
   input  logic                 emesh_write_outb,
   input  logic [1:0]           emesh_datamode_outb,
   input  logic [3:0]           emesh_ctrlmode_outb,
   input  logic [`EMESH_AW-1:0] emesh_dstaddr_outb,
   input  logic [`EMESH_AW-1:0] emesh_srcaddr_outb,
   input  logic [`EMESH_DW-1:0] emesh_data_outb,
   input  logic                 awready,
   input  logic                 wready,
   input  logic                 bvalid,
   output logic                 emesh_wr_wait_inb,
   output axi_pkg::axi_addr_t   awaddr,
   output axi_pkg::axi_size_t   awsize,
   output logic                 awvalid,
   output axi_pkg::axi_data_t   wdata,
   output axi_pkg::axi_strb_t   wstrb,
   output logic                 wlast,
   output logic                 wvalid,
   output logic                 bready
);

   emesh_pkg::emesh_packet_t in_pkt;     // packet at the emesh port
   emesh_pkg::emesh_packet_t head;       // oldest queued write
   logic                     fifo_empty;
   logic                     fifo_full;
   logic                     accept;     // packet taken this cycle
   logic                     busy;       // a beat still waits for ready
   logic                     load;       // start next beat, pops queue
   logic [2:0]               ofs;        // byte offset in the 64 bit beat
   axi_pkg::axi_strb_t       strb_base;  // strobes before shifting

   //############################################################
   // emesh intake
   //############################################################
   assign accept            = emesh_access_outb & emesh_write_outb & ~fifo_full;
   assign emesh_wr_wait_inb = fifo_full;  // sender holds while high

   assign in_pkt = '{write:    emesh_write_outb,
                     datamode: emesh_pkg::datamode_e'(emesh_datamode_outb),
                     ctrlmode: emesh_ctrlmode_outb,
                     dstaddr:  emesh_dstaddr_outb,
                     srcaddr:  emesh_srcaddr_outb,
                     data:     emesh_data_outb};

   packet_fifo #(
      .DEPTH   (`WR_DEPTH),
      .entry_t (emesh_pkg::emesh_packet_t)
   ) u_wr_fifo (
      .aclk      (aclk),
      .rst       (rst),
      .push      (accept),
      .push_data (in_pkt),
      .pop       (load),
      .pop_data  (head),
      .empty     (fifo_empty),
      .full      (fifo_full)
   );

   //############################################################
   // aw and w beats
   //############################################################
   assign busy = (awvalid & ~awready) | (wvalid & ~wready);  // either beat pending
   assign load = ~busy & ~fifo_empty;  // both beats done, next entry waiting
   assign ofs  = head.dstaddr[2:0];

   always_comb begin
      case (head.datamode)
         emesh_pkg::DM_BYTE: strb_base = 8'h01;
         emesh_pkg::DM_HALF: strb_base = 8'h03;
         emesh_pkg::DM_WORD: strb_base = 8'h0f;
         default:            strb_base = 8'hff;  // double, whole beat
      endcase
   end

   always_ff @(posedge aclk) begin
      if (rst) begin
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
      end else begin
         awvalid <= load | (awvalid & ~awready);  // rise together
         wvalid  <= load | (wvalid & ~wready);    // drop on own ready
      end
   end

   always_ff @(posedge aclk) begin
      if (load) begin
         awaddr <= {head.dstaddr[31:3], 3'b000};  // beat aligned
         awsize <= axi_pkg::axi_size_t'({1'b0, head.datamode});
         if (head.datamode == emesh_pkg::DM_DOUBLE) begin
            wdata <= {head.srcaddr, head.data};   // upper word from srcaddr
            wstrb <= strb_base;
         end else begin
            wdata <= {32'h0, head.data} << {ofs, 3'b000};  // into its byte lanes
            wstrb <= strb_base << ofs;
         end
      end
   end

   assign wlast = 1'b1;  // single beat bursts
   assign bready = 1'b1;  // responses always sunk, never inspected

endmodule

/* hdl/axi_master_rd.sv */
`timescale 1ns/1ns
`include "emesh_axi_defs.svh"

module axi_master_rd (
   input  logic                 aclk,
   input  logic                 rst,
   input  logic                 emesh_access_outb,
   input  logic                 emesh_write_outb,
   input  logic [1:0]           emesh_datamode_outb,
   input  logic [3:0]           emesh_ctrlmode_outb,
   input  logic [`EMESH_AW-1:0] emesh_dstaddr_outb,
   input  logic [`EMESH_AW-1:0] emesh_srcaddr_outb,
   input  logic [`EMESH_DW-1:0] emesh_data_outb,
   input  logic                 emesh_wr_wait_outb,
   input  logic                 arready,
   input  axi_pkg::axi_data_t   rdata,
   input  logic                 rvalid,
   input  logic                 rlast,
   output logic                 emesh_rd_wait_inb,
   output axi_pkg::axi_addr_t   araddr,
   output axi_pkg::axi_size_t   arsize,
   output logic                 arvalid,
   output logic                 rready,
   output logic                 emesh_access_inb,
   output logic                 emesh_write_inb,
   output logic [1:0]           emesh_datamode_inb,
   output logic [3:0]           emesh_ctrlmode_inb,
   output logic [`EMESH_AW-1:0] emesh_dstaddr_inb,
   output logic [`EMESH_AW-1:0] emesh_srcaddr_inb,
   output logic [`EMESH_DW-1:0] emesh_data_inb
);

   emesh_pkg::emesh_packet_t in_pkt;
   emesh_pkg::emesh_packet_t req;        // oldest queued read
   axi_pkg::rd_tag_t         new_tag;    // tag of the read being issued
   axi_pkg::rd_tag_t         tag;        // tag of the read being answered
   logic                     req_empty;
   logic                     req_full;
   logic                     tag_empty;
   logic                     tag_full;
   logic                     accept;
   logic                     load;       // ar beat starts, tag pushed
   logic                     r_hs;       // r beat taken
   logic [31:0]              lane_word;
   logic [31:0]              shifted;
   logic [`EMESH_DW-1:0]     reply_data;

   assign accept            = emesh_access_outb & ~emesh_write_outb & ~req_full;
   assign emesh_rd_wait_inb = req_full;

   assign in_pkt = '{write:    emesh_write_outb,
                     datamode: emesh_pkg::datamode_e'(emesh_datamode_outb),
                     ctrlmode: emesh_ctrlmode_outb,
                     dstaddr:  emesh_dstaddr_outb,
                     srcaddr:  emesh_srcaddr_outb,
                     data:     emesh_data_outb};

   packet_fifo #(.DEPTH(`RD_DEPTH), .entry_t(emesh_pkg::emesh_packet_t)) u_req_fifo (
      .aclk(aclk), .rst(rst), .push(accept), .push_data(in_pkt), .pop(load),
      .pop_data(req), .empty(req_empty), .full(req_full)
   );

   //############################################################
   // ar issue, one tag per outstanding read
   //############################################################
   assign load    = (~arvalid | arready) & ~req_empty & ~tag_full;  // tag slot needed
   assign new_tag = '{offset:   req.dstaddr[2:0],
                      datamode: req.datamode,
                      ctrlmode: req.ctrlmode,
                      retaddr:  req.srcaddr};

   packet_fifo #(.DEPTH(`RD_DEPTH), .entry_t(axi_pkg::rd_tag_t)) u_tag_fifo (
      .aclk(aclk), .rst(rst), .push(load), .push_data(new_tag), .pop(r_hs & rlast),
      .pop_data(tag), .empty(tag_empty), .full(tag_full)
   );

   always_ff @(posedge aclk) begin
      if (rst) arvalid <= 1'b0;
      else arvalid <= load | (arvalid & ~arready);
   end

   always_ff @(posedge aclk) begin
      if (load) begin
         araddr <= {req.dstaddr[31:3], 3'b000};
         arsize <= axi_pkg::axi_size_t'({1'b0, req.datamode});
      end
   end

   //############################################################
   // r data back to emesh
   //############################################################
   // free output slot, or one leaving this cycle; no tag means no read in flight
   assign rready    = (~emesh_access_inb | ~emesh_wr_wait_outb) & ~tag_empty;
   assign r_hs      = rvalid & rready;
   assign lane_word = tag.offset[2] ? rdata[63:32] : rdata[31:0];
   assign shifted   = lane_word >> {tag.offset[1:0], 3'b000};  // drop lower bytes

   always_comb begin
      case (tag.datamode)
         emesh_pkg::DM_BYTE: reply_data = {24'h0, shifted[7:0]};
         emesh_pkg::DM_HALF: reply_data = {16'h0, shifted[15:0]};
         emesh_pkg::DM_WORD: reply_data = shifted;
         default:            reply_data = rdata[31:0];  // double, lower word
      endcase
   end

   always_ff @(posedge aclk) begin
      if (rst) emesh_access_inb <= 1'b0;
      else if (r_hs) emesh_access_inb <= 1'b1;             // one cycle after r
      else if (~emesh_wr_wait_outb) emesh_access_inb <= 1'b0;  // drained
   end

   always_ff @(posedge aclk) begin
      if (r_hs) begin
         emesh_write_inb    <= 1'b1;  // replies are writes
         emesh_datamode_inb <= tag.datamode;
         emesh_ctrlmode_inb <= tag.ctrlmode;
         emesh_dstaddr_inb  <= tag.retaddr;
         emesh_data_inb     <= reply_data;
         emesh_srcaddr_inb  <= (tag.datamode == emesh_pkg::DM_DOUBLE) ? rdata[63:32] : '0;
      end
   end

endmodule

/* hdl/axi_master.sv */
`timescale 1ns/1ns
`include "emesh_axi_defs.svh"

module axi_master (
   input  logic                 aclk,
   input  logic                 rst,
   // write address
   output logic [`AXI_IDW-1:0]  awid,
   output axi_pkg::axi_addr_t   awaddr,
   output logic [3:0]           awlen,
   output axi_pkg::axi_size_t   awsize,
   output logic [1:0]           awburst,
   output logic [1:0]           awlock,
   output logic [3:0]           awcache,
   output logic [2:0]           awprot,
   output logic [3:0]           awqos,
   output logic                 awvalid,
   input  logic                 awready,
   // write data
   output logic [`AXI_IDW-1:0]  wid,
   output axi_pkg::axi_data_t   wdata,
   output axi_pkg::axi_strb_t   wstrb,
   output logic                 wlast,
   output logic                 wvalid,
   input  logic                 wready,
   // write response, sunk
   input  logic [`AXI_IDW-1:0]  bid,
   input  axi_pkg::axi_resp_e   bresp,
   input  logic                 bvalid,
   output logic                 bready,
   // read address
   output logic [`AXI_IDW-1:0]  arid,
   output axi_pkg::axi_addr_t   araddr,
   output logic [3:0]           arlen,
   output axi_pkg::axi_size_t   arsize,
   output logic [1:0]           arburst,
   output logic [1:0]           arlock,
   output logic [3:0]           arcache,
   output logic [2:0]           arprot,
   output logic [3:0]           arqos,
   output logic                 arvalid,
   input  logic                 arready,
   // read data
   input  logic [`AXI_IDW-1:0]  rid,
   input  axi_pkg::axi_data_t   rdata,
   input  axi_pkg::axi_resp_e   rresp,
   input  logic                 rlast,
   input  logic                 rvalid,
   output logic                 rready,
   // emesh from the mesh
   input  logic                 emesh_access_outb,
   input  logic                 emesh_write_outb,
   input  logic [1:0]           emesh_datamode_outb,
   input  logic [3:0]           emesh_ctrlmode_outb,
   input  logic [`EMESH_AW-1:0] emesh_dstaddr_outb,
   input  logic [`EMESH_AW-1:0] emesh_srcaddr_outb,
   input  logic [`EMESH_DW-1:0] emesh_data_outb,
   input  logic                 emesh_wr_wait_outb,
   // emesh back to the mesh
   output logic                 emesh_access_inb,
   output logic                 emesh_write_inb,
   output logic [1:0]           emesh_datamode_inb,
   output logic [3:0]           emesh_ctrlmode_inb,
   output logic [`EMESH_AW-1:0] emesh_dstaddr_inb,
   output logic [`EMESH_AW-1:0] emesh_srcaddr_inb,
   output logic [`EMESH_DW-1:0] emesh_data_inb,
   output logic                 emesh_wr_wait_inb,
   output logic                 emesh_rd_wait_inb
);

   //############################################################
   // fixed fields, single id and single beat
   //############################################################
   assign awid    = '0;
   assign wid     = '0;
   assign arid    = '0;     // in order replies
   assign awlen   = 4'h0;   // one beat
   assign arlen   = 4'h0;
   assign awburst = 2'b01;  // incr
   assign arburst = 2'b01;
   assign awlock  = 2'b00;  // normal access
   assign arlock  = 2'b00;
   assign awcache = 4'b0011;  // bufferable, modifiable
   assign arcache = 4'b0011;
   assign awprot  = 3'b000;
   assign arprot  = 3'b000;
   assign awqos   = 4'h0;   // axi4 only, held at 0
   assign arqos   = 4'h0;

   axi_master_wr u_wr (.*);  // aw, w, b

   axi_master_rd u_rd (.*);  // ar, r, reply packets

endmodule

/* dv/axi_master_chk.sv */
`timescale 1ns/1ns

module axi_master_chk (
   input logic               aclk,
   input logic               rst,
   input logic               awvalid,
   input logic               awready,
   input axi_pkg::axi_addr_t awaddr,
   input logic               wvalid,
   input logic               wready,
   input axi_pkg::axi_data_t wdata,
   input axi_pkg::axi_strb_t wstrb,
   input logic               arvalid,
   input logic               arready,
   input axi_pkg::axi_addr_t araddr,
   input logic               rvalid,
   input logic               rready,
   input logic               emesh_access_inb,
   input logic               emesh_wr_wait_outb,
   input logic [31:0]        emesh_dstaddr_inb,
   input logic [31:0]        emesh_srcaddr_inb,
   input logic [31:0]        emesh_data_inb
);

   //############################################################
   // valid and payload hold until ready
   //############################################################
   aw_hold: assert property (@(posedge aclk) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(awaddr))
      else $error("awvalid or awaddr changed before awready");
   w_hold: assert property (@(posedge aclk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
      else $error("wvalid, wdata or wstrb changed before wready");
   ar_hold: assert property (@(posedge aclk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else $error("arvalid or araddr changed before arready");

   // reply register frozen under mesh wait
   reply_hold: assert property (@(posedge aclk) disable iff (rst)
      emesh_access_inb && emesh_wr_wait_outb |=> emesh_access_inb
         && $stable({emesh_dstaddr_inb, emesh_srcaddr_inb, emesh_data_inb}))
      else $error("reply packet changed while emesh_wr_wait_outb was high");

   // reply register loads one edge after the r beat
   r_to_reply: assert property (@(posedge aclk) disable iff (rst)
      rvalid && rready |=> emesh_access_inb)
      else $error("no reply packet one cycle after the r beat");

   // sync reset, outputs clear one edge in
   reset_quiet: assert property (@(posedge aclk)
      rst |=> !(awvalid || wvalid || arvalid || emesh_access_inb))
      else $error("valid or access output high during reset");

endmodule

bind axi_master axi_master_chk u_chk (.*);

/* dv/axi_master_tb.sv */
`timescale 1ns/1ns
`include "emesh_axi_defs.svh"

module axi_master_tb;

   localparam int MAX_CYCLES = 400 * 40;  // packets times worst cycles per packet

   typedef struct packed {
      axi_pkg::axi_addr_t addr;
      axi_pkg::axi_data_t data;
      axi_pkg::axi_strb_t strb;
      axi_pkg::axi_size_t size;
   } beat_t;

   logic aclk, rst;
   logic [`AXI_IDW-1:0] awid, wid, arid, bid, rid;
   axi_pkg::axi_addr_t awaddr, araddr;
   axi_pkg::axi_size_t awsize, arsize;
   logic [3:0] awlen, arlen, awcache, arcache, awqos, arqos;
   logic [1:0] awburst, arburst, awlock, arlock;
   logic [2:0] awprot, arprot;
   logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rlast, rvalid, rready;
   axi_pkg::axi_data_t wdata, rdata;
   axi_pkg::axi_strb_t wstrb;
   axi_pkg::axi_resp_e bresp, rresp;
   logic emesh_access_outb, emesh_write_outb, emesh_wr_wait_outb;
   logic emesh_access_inb, emesh_write_inb, emesh_wr_wait_inb, emesh_rd_wait_inb;
   logic [1:0] emesh_datamode_outb, emesh_datamode_inb;
   logic [3:0] emesh_ctrlmode_outb, emesh_ctrlmode_inb;
   logic [31:0] emesh_dstaddr_outb, emesh_srcaddr_outb, emesh_data_outb;
   logic [31:0] emesh_dstaddr_inb, emesh_srcaddr_inb, emesh_data_inb;

   logic [31:0] lfsr = 32'hbbd3_9217;
   axi_pkg::axi_data_t shadow[axi_pkg::axi_addr_t];     // model memory
   axi_pkg::axi_data_t slave_mem[axi_pkg::axi_addr_t];  // slave memory
   beat_t exp_beats[$], exp_ars[$], aw_q[$], w_q[$];
   axi_pkg::axi_addr_t ar_q[$];
   emesh_pkg::emesh_packet_t exp_replies[$];
   int cycles, errors, test_errors, checks, wait_seen;
   logic stall_axi, stall_out, r_taken;
   string test_name;

   axi_master uut (.*);

   initial begin
      aclk = 1'b0;
      forever #50 aclk = ~aclk;
   end

   //############################################################
   // helpers
   //############################################################
   function automatic logic [31:0] rnd(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic axi_pkg::axi_data_t fill(input axi_pkg::axi_addr_t a);
      return {~a, a};  // unwritten beats
   endfunction

   function automatic axi_pkg::axi_data_t byte_mask(input axi_pkg::axi_strb_t s);
      axi_pkg::axi_data_t m;
      for (int i = 0; i < 8; i++) m[i*8 +: 8] = {8{s[i]}};
      return m;
   endfunction

   function automatic axi_pkg::axi_data_t merge(input axi_pkg::axi_data_t old,
         input axi_pkg::axi_data_t d, input axi_pkg::axi_strb_t s);
      return (old & ~byte_mask(s)) | (d & byte_mask(s));
   endfunction

   // log2 of the bytes one access moves
   function automatic axi_pkg::axi_size_t size_of(input emesh_pkg::datamode_e dm);
      case (dm)
         emesh_pkg::DM_BYTE: return 3'd0;  // 1 byte
         emesh_pkg::DM_HALF: return 3'd1;  // 2 bytes
         emesh_pkg::DM_WORD: return 3'd2;  // 4 bytes
         default:            return 3'd3;  // 8 bytes
      endcase
   endfunction

   task automatic check_packet(input emesh_pkg::emesh_packet_t exp_p,
         input emesh_pkg::emesh_packet_t act_p);
      checks++;
      if (exp_p !== act_p) begin
         errors++;
         test_errors++;
         $display("[FAIL] %s reply expected %h actual %h", test_name, exp_p, act_p);
      end
   endtask

   task automatic check_beat(input axi_pkg::axi_addr_t ea, input axi_pkg::axi_data_t ed,
         input axi_pkg::axi_strb_t es, input axi_pkg::axi_addr_t aa,
         input axi_pkg::axi_data_t ad, input axi_pkg::axi_strb_t as);
      checks++;
      if ({ea, ed, es} !== {aa, ad, as}) begin
         errors++;
         test_errors++;
         $display("[FAIL] %s beat expected %h/%h/%h actual %h/%h/%h",
                  test_name, ea, ed, es, aa, ad, as);
      end
   endtask

   task automatic check_size(input axi_pkg::axi_size_t exp_s,
         input axi_pkg::axi_size_t act_s);
      checks++;
      if (exp_s !== act_s) begin
         errors++;
         test_errors++;
         $display("[FAIL] %s size expected %0d actual %0d", test_name, exp_s, act_s);
      end
   endtask

   task automatic check_fixed(input logic [57:0] exp_f, input logic [57:0] act_f);
      checks++;
      if (exp_f !== act_f) begin
         errors++;
         test_errors++;
         $display("[FAIL] %s tied fields expected %h actual %h", test_name, exp_f, act_f);
      end
   endtask

   //############################################################
   // reference model, updated on each accepted packet
   //############################################################
   task automatic model_accept(input emesh_pkg::emesh_packet_t p);
      axi_pkg::axi_addr_t       a;
      axi_pkg::axi_data_t       d, cur;
      axi_pkg::axi_strb_t       s;
      logic [2:0]               ofs;
      logic [31:0]              lane;
      emesh_pkg::emesh_packet_t r;
      beat_t                    bt;
      a   = {p.dstaddr[31:3], 3'b000};
      ofs = p.dstaddr[2:0];
      cur = shadow.exists(a) ? shadow[a] : fill(a);
      if (p.write) begin
         case (p.datamode)
            emesh_pkg::DM_BYTE: s = 8'h01 << ofs;
            emesh_pkg::DM_HALF: s = 8'h03 << ofs;
            emesh_pkg::DM_WORD: s = 8'h0f << ofs;
            default:            s = 8'hff;
         endcase
         d = (p.datamode == emesh_pkg::DM_DOUBLE) ? {p.srcaddr, p.data}
                                                  : {32'h0, p.data} << (8 * ofs);
         bt = '{a, d & byte_mask(s), s, size_of(p.datamode)};
         exp_beats.push_back(bt);
         shadow[a] = merge(cur, d, s);
      end else begin
         bt = '{a, '0, '0, size_of(p.datamode)};  // ar beat, no data
         exp_ars.push_back(bt);
         lane = (ofs[2] ? cur[63:32] : cur[31:0]) >> (8 * ofs[1:0]);
         case (p.datamode)
            emesh_pkg::DM_BYTE: lane = lane & 32'hff;
            emesh_pkg::DM_HALF: lane = lane & 32'hffff;
            emesh_pkg::DM_WORD: lane = lane;
            default:            lane = cur[31:0];  // lower word, upper in srcaddr
         endcase
         r = '{write: 1'b1, datamode: p.datamode, ctrlmode: p.ctrlmode,
               dstaddr: p.srcaddr, data: lane,
               srcaddr: (p.datamode == emesh_pkg::DM_DOUBLE) ? cur[63:32] : 32'h0};
         exp_replies.push_back(r);
      end
   endtask

   function automatic emesh_pkg::emesh_packet_t make_pkt(input logic wr,
         input logic [31:0] base);
      emesh_pkg::emesh_packet_t p;
      logic [1:0]               dm;
      dm         = rnd(2);
      p.write    = wr;
      p.datamode = emesh_pkg::datamode_e'(dm);
      p.ctrlmode = rnd(4);
      p.data     = rnd(32);
      p.srcaddr  = rnd(32);
      p.dstaddr  = base | (rnd(6) << 3);  // 64 beats per range
      case (p.datamode)  // naturally aligned offsets
         emesh_pkg::DM_BYTE: p.dstaddr = p.dstaddr | rnd(3);
         emesh_pkg::DM_HALF: p.dstaddr = p.dstaddr | (rnd(2) << 1);
         emesh_pkg::DM_WORD: p.dstaddr = p.dstaddr | (rnd(1) << 2);
         default:            p.dstaddr = p.dstaddr;
      endcase
      return p;
   endfunction

   task automatic send(input emesh_pkg::emesh_packet_t p);
      @(negedge aclk);
      emesh_access_outb   = 1'b1;
      emesh_write_outb    = p.write;
      emesh_datamode_outb = p.datamode;
      emesh_ctrlmode_outb = p.ctrlmode;
      emesh_dstaddr_outb  = p.dstaddr;
      emesh_srcaddr_outb  = p.srcaddr;
      emesh_data_outb     = p.data;
      do @(posedge aclk); while (p.write ? emesh_wr_wait_inb : emesh_rd_wait_inb);
      model_accept(p);
   endtask

   task automatic run_test(input string name, input int n, input int mode,
         input logic [31:0] wbase);
      logic wr;
      test_name   = name;
      test_errors = 0;
      wait_seen   = 0;
      repeat (n) begin
         wr = (mode == 2) ? rnd(1) : (mode == 0);
         send(make_pkt(wr, wr ? wbase : 32'h1000));
      end
      @(negedge aclk) emesh_access_outb = 1'b0;
      while (exp_beats.size() != 0 || exp_replies.size() != 0) @(posedge aclk);
      foreach (shadow[k])
         check_beat(k, shadow[k], 8'hff, k, slave_mem.exists(k) ? slave_mem[k] : fill(k), 8'hff);
      if (stall_axi && wait_seen == 0) begin
         errors++;
         test_errors++;
         $display("%s: emesh wait outputs never rose under AXI stalls", name);
      end
      $display("test %s done, %0d errors", name, test_errors);
   endtask

   //############################################################
   // axi slave and reply monitor
   //############################################################
   always @(posedge aclk) begin : slave_side
      axi_pkg::axi_addr_t       a;
      beat_t                    aw, b, e;
      emesh_pkg::emesh_packet_t got;
      if (!rst) begin
         if (emesh_wr_wait_inb || emesh_rd_wait_inb) wait_seen++;
         if (awvalid && awready) begin
            aw = '{awaddr, '0, '0, awsize};
            aw_q.push_back(aw);
         end
         if (wvalid && wready) begin
            b = '{32'h0, wdata, wstrb, 3'd0};
            w_q.push_back(b);
         end
         if (arvalid && arready) begin
            ar_q.push_back(araddr);
            if (exp_ars.size() == 0) begin
               errors++;
               test_errors++;
               $display("%s: read address seen with no packet behind it", test_name);
            end else begin
               e = exp_ars.pop_front();
               check_beat(e.addr, '0, '0, araddr, '0, '0);
               check_size(e.size, arsize);
            end
         end
         if (rvalid && rready) r_taken = 1'b1;
         if (aw_q.size() != 0 && w_q.size() != 0) begin
            aw = aw_q.pop_front();
            b  = w_q.pop_front();
            a  = aw.addr;
            if (exp_beats.size() == 0) begin
               errors++;
               test_errors++;
               $display("%s: write beat seen with no packet behind it", test_name);
            end else begin
               e = exp_beats.pop_front();
               check_beat(e.addr, e.data, e.strb, a, b.data & byte_mask(b.strb), b.strb);
               check_size(e.size, aw.size);
            end
            slave_mem[a] = merge(slave_mem.exists(a) ? slave_mem[a] : fill(a), b.data, b.strb);
         end
         if (emesh_access_inb && !emesh_wr_wait_outb) begin  // reply leaves
            if (exp_replies.size() == 0) begin
               errors++;
               test_errors++;
               $display("%s: reply packet seen with no read behind it", test_name);
            end else begin
               got = '{write: emesh_write_inb,
                       datamode: emesh_pkg::datamode_e'(emesh_datamode_inb),
                       ctrlmode: emesh_ctrlmode_inb, dstaddr: emesh_dstaddr_inb,
                       srcaddr: emesh_srcaddr_inb, data: emesh_data_inb};
               check_packet(exp_replies.pop_front(), got);
            end
         end
      end
   end

   always @(negedge aclk) begin : slave_drive
      axi_pkg::axi_addr_t a;
      if (!rst) begin
         awready            = !stall_axi || rnd(2) == 0;  // a quarter of cycles
         wready             = !stall_axi || rnd(2) == 0;
         arready            = !stall_axi || rnd(2) == 0;
         emesh_wr_wait_outb = stall_out && rnd(1);
         if (r_taken) begin
            rvalid  = 1'b0;
            r_taken = 1'b0;
         end
         if (!rvalid && ar_q.size() != 0 && (!stall_axi || rnd(1))) begin
            a      = ar_q.pop_front();
            rdata  = slave_mem.exists(a) ? slave_mem[a] : fill(a);
            rvalid = 1'b1;  // in order, okay
         end
      end
   end

   always @(posedge aclk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Checks failed");
         $finish;
      end
   end

   //############################################################
   // test sequence
   //############################################################
   initial begin
      {awready, wready, arready, rvalid, rlast, bvalid} = 6'b000010;
      {bid, rid, rdata} = '0;
      bresp = axi_pkg::RESP_OKAY;
      rresp = axi_pkg::RESP_OKAY;
      {emesh_access_outb, emesh_write_outb, emesh_wr_wait_outb} = 3'b000;
      {emesh_datamode_outb, emesh_ctrlmode_outb} = '0;
      {emesh_dstaddr_outb, emesh_srcaddr_outb, emesh_data_outb} = '0;
      {stall_axi, stall_out, r_taken} = 3'b000;
      {cycles, errors, checks, wait_seen} = '0;
      rst = 1'b1;
      repeat (8) @(posedge aclk);
      @(negedge aclk) rst = 1'b0;
      @(posedge aclk);
      test_name = "reset";
      checks++;
      if (awvalid | wvalid | arvalid | emesh_access_inb | emesh_wr_wait_inb
          | emesh_rd_wait_inb) begin
         errors++;
         $display("reset: a valid, access or wait output is high after reset");
      end
      // ids, lens, incr bursts, locks, cache 0011, prot, qos, wlast and bready
      check_fixed({18'h0, 8'h0, 4'b0101, 4'b0000, 8'b0011_0011, 6'h0, 8'h0, 2'b11},
                  {awid, wid, arid, awlen, arlen, awburst, arburst, awlock, arlock,
                   awcache, arcache, awprot, arprot, awqos, arqos, wlast, bready});
      $display("test reset done");
      run_test("write", 60, 0, 32'h1000);
      run_test("read", 60, 1, 32'h1000);
      stall_axi = 1'b1;
      run_test("axi_stall", 80, 2, 32'h2000);
      stall_axi = 1'b0;
      stall_out = 1'b1;
      run_test("reply_stall", 60, 1, 32'h1000);
      stall_axi = 1'b1;
      run_test("mixed", 100, 2, 32'h3000);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) $display("All checks passed");
      else $display("Checks failed");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+hdl
hdl/emesh_pkg.sv
hdl/axi_pkg.sv
hdl/packet_fifo.sv
hdl/axi_master_wr.sv
hdl/axi_master_rd.sv
hdl/axi_master.sv
dv/axi_master_chk.sv
dv/axi_master_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the axi_master testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module axi_master_tb -f filelist.f

./obj_dir/Vaxi_master_tb | tee sim.log

if grep -q "All checks passed" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
